// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal -j 0
TOP       = bbframe_timing_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
rtl/bbframe_pkg.sv
rtl/modcod_decode.sv
rtl/frame_slot_counter.sv
rtl/slot_window_gen.sv
rtl/bbframe_timing_top.sv
tb/bbframe_timing_checker.sv
tb/bbframe_timing_tb.sv

// ==== rtl/bbframe_pkg.sv ====
`default_nettype none

package bbframe_pkg;

	////////////////////
	// widths
	////////////////////

	// slot index or count inside one PL frame, longest frame is 33282 slots
	typedef logic [15:0] slot_t;

	// byte count inside one BBFRAME
	typedef logic [12:0] bytes_t;

	////////////////////
	// standard constants
	////////////////////

	// BBFRAME header bytes on top of the TS payload
	localparam int BBHDR_BYTES = 10;

	// MPEG TS packet length
	localparam int TS_PKT_BYTES = 188;

	// valid code rates per frame size
	localparam int NUM_RATES_NORMAL = 11;
	localparam int NUM_RATES_SHORT  = 10;

	////////////////////
	// length tables
	////////////////////

	// Kbch in bytes, normal frame, by code rate
	localparam bytes_t KBCH_NORMAL [NUM_RATES_NORMAL] = '{
		13'd2001, 13'd2676, 13'd3216, 13'd4026,
		13'd4836, 13'd5380, 13'd6051, 13'd6456,
		13'd6730, 13'd7184, 13'd7274
	};

	// Kbch in bytes, short frame, by code rate
	localparam bytes_t KBCH_SHORT [NUM_RATES_SHORT] = '{
		13'd384,  13'd654,  13'd789,  13'd879,
		13'd1194, 13'd1329, 13'd1464, 13'd1554,
		13'd1644, 13'd1779
	};

	// PL frame length in slots
	// index is {frame_short, pilot_on, constellation}
	// constellation 0..3 is QPSK, 8PSK, 16APSK, 32APSK
	localparam slot_t PLFRAME_LEN [16] = '{
		// normal, no pilots
		16'd32490, 16'd21690, 16'd16290, 16'd13050,
		// normal, pilots
		16'd33282, 16'd22194, 16'd16686, 16'd13338,
		// short, no pilots
		16'd8190,  16'd5490,  16'd4140,  16'd3330,
		// short, pilots
		16'd8370,  16'd5598,  16'd4212,  16'd3402
	};

endpackage

`default_nettype wire

// ==== rtl/bbframe_timing_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module bbframe_timing_top import bbframe_pkg::*; #(
	parameter int PKT_BYTES = TS_PKT_BYTES
) (
	input  logic       sys_clk,
	input  logic       glb_rst_n,
	input  logic       frame_short,
	input  logic [3:0] code_rate,
	input  logic       pilot_on,
	input  logic [1:0] constellation,
	input  logic       sym_stb,
	output logic       frame_start,
	output logic       bbframe_vld,
	output logic       ts_rd_vld,
	output logic       ts_rd_head
);

	// decoded lengths
	slot_t  frame_len;
	bytes_t kbch_len;
	bytes_t ts_len;

	// per-slot info for the window stage
	logic   slot_stb;
	slot_t  slot_idx;
	bytes_t cur_kbch;
	bytes_t cur_ts;

	////////////////////
	// stages
	////////////////////

	// MODCOD to lengths, one cycle
	modcod_decode modcod_decode_i (
		.sys_clk       (sys_clk),
		.glb_rst_n     (glb_rst_n),
		.frame_short   (frame_short),
		.code_rate     (code_rate),
		.pilot_on      (pilot_on),
		.constellation (constellation),
		.frame_len     (frame_len),
		.kbch_len      (kbch_len),
		.ts_len        (ts_len)
	);

	// strobe to slot, one cycle
	frame_slot_counter frame_slot_counter_i (
		.sys_clk   (sys_clk),
		.glb_rst_n (glb_rst_n),
		.sym_stb   (sym_stb),
		.frame_len (frame_len),
		.kbch_len  (kbch_len),
		.ts_len    (ts_len),
		.slot_stb  (slot_stb),
		.slot_idx  (slot_idx),
		.cur_kbch  (cur_kbch),
		.cur_ts    (cur_ts)
	);

	// slot to output flags, one cycle
	slot_window_gen #(
		.PKT_BYTES (PKT_BYTES)
	) slot_window_gen_i (
		.sys_clk     (sys_clk),
		.glb_rst_n   (glb_rst_n),
		.slot_stb    (slot_stb),
		.slot_idx    (slot_idx),
		.cur_kbch    (cur_kbch),
		.cur_ts      (cur_ts),
		.frame_start (frame_start),
		.bbframe_vld (bbframe_vld),
		.ts_rd_vld   (ts_rd_vld),
		.ts_rd_head  (ts_rd_head)
	);

endmodule

`default_nettype wire

// ==== rtl/frame_slot_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_slot_counter import bbframe_pkg::*; (
	input  logic   sys_clk,
	input  logic   glb_rst_n,
	input  logic   sym_stb,
	input  slot_t  frame_len,
	input  bytes_t kbch_len,
	input  bytes_t ts_len,
	output logic   slot_stb,
	output slot_t  slot_idx,
	output bytes_t cur_kbch,
	output bytes_t cur_ts
);

	// slot taken by the next strobe
	slot_t next_slot;
	// frame length held for the running frame
	slot_t frame_len_q;
	// length in force for the slot being issued
	slot_t len_now;
	slot_t slot_inc;
	logic  at_start;

	////////////////////
	// next slot
	////////////////////

	always_comb begin
		at_start = (next_slot == '0);
		// slot 0 already sees the new frame length
		len_now  = at_start ? frame_len : frame_len_q;
		slot_inc = next_slot + 16'd1;
	end

	////////////////////
	// slot register
	////////////////////

	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			next_slot   <= '0;
			frame_len_q <= '0;
			cur_kbch    <= '0;
			cur_ts      <= '0;
			slot_stb    <= 1'b0;
			slot_idx    <= '0;
		end else begin
			// one strobe per cycle at most, pass it on
			slot_stb <= sym_stb;
			if (sym_stb) begin
				slot_idx <= next_slot;
				// wrap after the last slot of the frame
				if (slot_inc >= len_now) begin
					next_slot <= '0;
				end else begin
					next_slot <= slot_inc;
				end
				// all three lengths latched together at frame start
				if (at_start) begin
					frame_len_q <= frame_len;
					cur_kbch    <= kbch_len;
					cur_ts      <= ts_len;
				end
			end
		end
	end

	// issued slot stays inside the latched frame
	a_slot_range: assert property (@(posedge sys_clk) disable iff (!glb_rst_n)
		(slot_stb && frame_len_q != '0) |-> (slot_idx < frame_len_q));

endmodule

`default_nettype wire

// ==== rtl/modcod_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module modcod_decode import bbframe_pkg::*; (
	input  logic       sys_clk,
	input  logic       glb_rst_n,
	input  logic       frame_short,
	input  logic [3:0] code_rate,
	input  logic       pilot_on,
	input  logic [1:0] constellation,
	output slot_t      frame_len,
	output bytes_t     kbch_len,
	output bytes_t     ts_len
);

	logic   rate_ok;
	bytes_t kbch_nxt;
	slot_t  pl_nxt;

	////////////////////
	// table lookup
	////////////////////

	always_comb begin
		// code rate range depends on frame size
		if (frame_short) begin
			rate_ok = (code_rate < NUM_RATES_SHORT);
		end else begin
			rate_ok = (code_rate < NUM_RATES_NORMAL);
		end
		// bad rate -> no BBFRAME at all
		kbch_nxt = '0;
		if (rate_ok && frame_short) begin
			kbch_nxt = KBCH_SHORT[code_rate];
		end else if (rate_ok) begin
			kbch_nxt = KBCH_NORMAL[code_rate];
		end
		// PL length is always defined
		pl_nxt = PLFRAME_LEN[{frame_short, pilot_on, constellation}];
	end

	////////////////////
	// output registers
	////////////////////

	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			frame_len <= '0;
			kbch_len  <= '0;
			ts_len    <= '0;
		end else begin
			frame_len <= pl_nxt;
			kbch_len  <= kbch_nxt;
			// TS payload is Kbch less the header
			ts_len    <= (kbch_nxt != '0) ? kbch_nxt - bytes_t'(BBHDR_BYTES) : '0;
		end
	end

	// BBFRAME window must fit inside the PL frame
	a_kbch_fits: assert property (@(posedge sys_clk) disable iff (!glb_rst_n)
		(kbch_len != '0) |-> (slot_t'(kbch_len) < frame_len));

endmodule

`default_nettype wire

// ==== rtl/slot_window_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module slot_window_gen import bbframe_pkg::*; #(
	parameter int PKT_BYTES = TS_PKT_BYTES
) (
	input  logic   sys_clk,
	input  logic   glb_rst_n,
	input  logic   slot_stb,
	input  slot_t  slot_idx,
	input  bytes_t cur_kbch,
	input  bytes_t cur_ts,
	output logic   frame_start,
	output logic   bbframe_vld,
	output logic   ts_rd_vld,
	output logic   ts_rd_head
);

	// packet byte counter width, at least one bit
	localparam int CNT_W = (PKT_BYTES > 1) ? $clog2(PKT_BYTES) : 1;

	logic             in_bb;
	logic             in_ts;
	logic             pkt_last;
	logic [CNT_W-1:0] pkt_cnt;

	////////////////////
	// window compare
	////////////////////

	always_comb begin
		// both windows open at slot 1
		in_bb    = (slot_idx != '0) && (slot_idx <= slot_t'(cur_kbch));
		in_ts    = (slot_idx != '0) && (slot_idx <= slot_t'(cur_ts));
		pkt_last = (pkt_cnt == CNT_W'(PKT_BYTES - 1));
	end

	////////////////////
	// output flags
	////////////////////

	always_ff @(posedge sys_clk or negedge glb_rst_n) begin
		if (!glb_rst_n) begin
			frame_start <= 1'b0;
			bbframe_vld <= 1'b0;
			ts_rd_vld   <= 1'b0;
			ts_rd_head  <= 1'b0;
			pkt_cnt     <= '0;
		end else begin
			// flags only live in strobed cycles
			frame_start <= slot_stb && (slot_idx == '0);
			bbframe_vld <= slot_stb && in_bb;
			ts_rd_vld   <= slot_stb && in_ts;
			// head on read 0, PKT_BYTES, 2*PKT_BYTES ...
			ts_rd_head  <= slot_stb && in_ts && (pkt_cnt == '0);
			// runs across frames, never cleared at frame start
			if (slot_stb && in_ts) begin
				pkt_cnt <= pkt_last ? '0 : pkt_cnt + 1'b1;
			end
		end
	end

	// TS payload sits inside the BBFRAME window
	a_ts_in_bb: assert property (@(posedge sys_clk) disable iff (!glb_rst_n)
		ts_rd_vld |-> bbframe_vld);

endmodule

`default_nettype wire

// ==== tb/bbframe_timing_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module bbframe_timing_checker import bbframe_pkg::*; (
	input  logic       sys_clk,
	input  logic       glb_rst_n,
	input  logic       frame_short,
	input  logic [3:0] code_rate,
	input  logic       pilot_on,
	input  logic [1:0] constellation,
	input  logic       sym_stb,
	input  logic       frame_start,
	input  logic       bbframe_vld,
	input  logic       ts_rd_vld,
	input  logic       ts_rd_head,
	input  logic       test_end,
	output int         err_cnt,
	output int         chk_cnt
);

	// lengths of the settings one cycle back, what the decoder holds now
	int         prev_pl;
	int         prev_kbch;
	// model slot count and lengths of the running frame
	int         next_slot;
	int         len_frame;
	int         len_kbch;
	int         len_ts;
	// TS reads since reset, runs across frames
	int         rd_cnt;
	// expected fs/bb/ts/head, one and two cycles out
	logic [3:0] exp_d1;
	logic [3:0] exp_d2;
	int         test_num = 0;
	int         test_err = 0;
	int         test_frames = 0;

	////////////////////
	// model and compare
	////////////////////

	// sampled mid-cycle, inputs and outputs both settled
	always @(negedge sys_clk) begin
		if (glb_rst_n !== 1'b1) begin
			next_slot = 0;
			rd_cnt    = 0;
			exp_d1    = '0;
			exp_d2    = '0;
			err_cnt   = 0;
			chk_cnt   = 0;
		end else begin
			chk_cnt = chk_cnt + 1;
			if ({frame_start, bbframe_vld, ts_rd_vld, ts_rd_head} !== exp_d2) begin
				$display("Error at %0d ns: fs/bb/ts/head %b, expected %b", $time,
					{frame_start, bbframe_vld, ts_rd_vld, ts_rd_head}, exp_d2);
				err_cnt  = err_cnt + 1;
				test_err = test_err + 1;
			end
			test_frames = test_frames + int'(frame_start);
			exp_d2 = exp_d1;
			exp_d1 = '0;
			if (sym_stb) begin
				// slot 0 latches all three lengths for the whole frame
				if (next_slot == 0) begin
					len_frame = prev_pl;
					len_kbch  = prev_kbch;
					len_ts    = (prev_kbch > 0) ? prev_kbch - BBHDR_BYTES : 0;
				end
				exp_d1[3] = (next_slot == 0);
				exp_d1[2] = (next_slot >= 1) && (next_slot <= len_kbch);
				exp_d1[1] = (next_slot >= 1) && (next_slot <= len_ts);
				// head on read 0, 188, 376 ...
				exp_d1[0] = exp_d1[1] && (rd_cnt % TS_PKT_BYTES == 0);
				rd_cnt    = rd_cnt + int'(exp_d1[1]);
				next_slot = (next_slot + 1 == len_frame) ? 0 : next_slot + 1;
			end
		end
		// table lookup straight from the standard values
		prev_pl   = int'(PLFRAME_LEN[{frame_short, pilot_on, constellation}]);
		prev_kbch = 0;
		if (frame_short && code_rate < NUM_RATES_SHORT) begin
			prev_kbch = int'(KBCH_SHORT[code_rate]);
		end else if (!frame_short && code_rate < NUM_RATES_NORMAL) begin
			prev_kbch = int'(KBCH_NORMAL[code_rate]);
		end
		if (test_end === 1'b1) begin
			$display("test %0d: %s rate %0d pilot %0b const %0d, %0d frame starts, %0d errors",
				test_num, frame_short ? "short" : "normal", code_rate, pilot_on,
				constellation, test_frames, test_err);
			test_num    = test_num + 1;
			test_err    = 0;
			test_frames = 0;
		end
	end

endmodule

`default_nettype wire

// ==== tb/bbframe_timing_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module bbframe_timing_tb import bbframe_pkg::*; ();

	localparam int NUM_TESTS = 8;
	// strobe density in percent
	localparam int STB_PCT   = 70;

	logic       sys_clk = 1'b0;
	logic       glb_rst_n;
	logic       frame_short;
	logic [3:0] code_rate;
	logic       pilot_on;
	logic [1:0] constellation;
	logic       sym_stb;
	logic       frame_start;
	logic       bbframe_vld;
	logic       ts_rd_vld;
	logic       ts_rd_head;
	logic       stb_en;
	logic       test_end;
	int         err_cnt;
	int         chk_cnt;
	int         starts;
	longint     cyc_cnt   = 0;
	// grows as each test is drawn
	longint     cyc_limit = 200;

	always #10 sys_clk = ~sys_clk;

	bbframe_timing_top bbframe_timing_top_i (.*);

	bbframe_timing_checker timing_check_i (.*);

	// random MODCOD with mostly short frames
	task automatic draw_modcod(input bit force_bad);
		frame_short   = ($urandom_range(3) != 0);
		code_rate     = 4'($urandom_range(frame_short ? 11 : 12));
		pilot_on      = 1'($urandom_range(1));
		constellation = 2'($urandom_range(3));
		// rate past the table gives frame starts only
		if (force_bad) begin
			code_rate = 4'd13;
		end
		// twice three frames at the strobe density
		cyc_limit = cyc_limit
			+ 6 * longint'(PLFRAME_LEN[{frame_short, pilot_on, constellation}]) * 100 / STB_PCT;
	endtask

	////////////////////
	// strobe and timeout
	////////////////////

	always @(posedge sys_clk) begin
		#2;
		sym_stb = stb_en && ($urandom_range(99) < STB_PCT);
	end

	always @(posedge sys_clk) begin
		cyc_cnt = cyc_cnt + 1;
		if (cyc_cnt > cyc_limit) begin
			$display("timeout: tests still running after %0d cycles", cyc_cnt);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	////////////////////
	// test sequence
	////////////////////

	initial begin
		glb_rst_n = 1'b0;
		sym_stb   = 1'b0;
		stb_en    = 1'b0;
		test_end  = 1'b0;
		void'($urandom(25));
		draw_modcod(1'b0);
		repeat (3) @(posedge sys_clk);
		#2;
		glb_rst_n = 1'b1;
		// let the decoder fill before the first strobe
		repeat (4) @(posedge sys_clk);
		stb_en = 1'b1;
		for (int t = 0; t < NUM_TESTS; t++) begin
			// first frame start and then two whole frames
			starts = 0;
			while (starts < 3) begin
				@(posedge sys_clk);
				#2;
				if (frame_start) begin
					starts++;
				end
			end
			test_end = 1'b1;
			@(posedge sys_clk);
			#2;
			test_end = 1'b0;
			// new settings land mid-frame
			if (t + 1 < NUM_TESTS) begin
				draw_modcod(t == 0);
			end
		end
		@(posedge sys_clk);
		stb_en = 1'b0;
		repeat (4) @(posedge sys_clk);
		$display("summary: %0d tests, %0d cycles checked, %0d errors",
			NUM_TESTS, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
